/* common/acq_pkg.sv */
`default_nettype none

package acq_pkg;

   // sample path
   localparam int SAMPLE_W   = 24;
   localparam int BUF_ADDR_W = 9;
   localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;  // 512 entries

   // word store standing in for the SDRAM
   localparam int STORE_ADDR_W   = 4;
   localparam int STORE_DEPTH    = 1 << STORE_ADDR_W;  // 16 words
   localparam int STORE_DATA_W   = 32;
   localparam int STORE_BUSY     = 3;  // ready low after each command
   localparam int STORE_READ_LAT = 3;  // enable cycle to valid strobe
   localparam int BUSY_CNT_W     = $clog2(STORE_BUSY + 1);

   // scheduler phases
   typedef enum logic [2:0]
   {
      AQ_WAITING         = 3'd0,
      AQ_BUFFER_TO_STORE = 3'd1,
      RB_ISSUE           = 3'd2,
      RB_IDLE            = 3'd3,
      FINISHED           = 3'd4
   } sched_phase_t;

   // command port opcode
   typedef enum logic
   {
      STORE_READ  = 1'b0,
      STORE_WRITE = 1'b1
   } store_op_t;

endpackage

`default_nettype wire

/* source/capture_writer.sv */
`default_nettype none

module capture_writer
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          acquire,
   input  logic [acq_pkg::SAMPLE_W-1:0]   sample_data,
   input  logic [acq_pkg::BUF_ADDR_W-1:0] rd_address,
   output logic                          wr_en,
   output logic [acq_pkg::BUF_ADDR_W-1:0] wr_address,
   output logic [acq_pkg::SAMPLE_W-1:0]   wr_data
);

   import acq_pkg::*;

   logic                  acquire_meta;  // first stage, may go metastable
   logic                  acquire_sync;
   logic [BUF_ADDR_W-1:0] next_address;
   logic                  buf_full;

   // two-flop synchronizer for the acquire level
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         acquire_meta <= 1'b0;
         acquire_sync <= 1'b0;
      end
      else
      begin
         acquire_meta <= acquire;
         acquire_sync <= acquire_meta;
      end
   end

   assign next_address = wr_address + 1'b1;
   assign buf_full     = (next_address == rd_address);  // one slot kept free
   assign wr_en        = acquire_sync && !buf_full;
   assign wr_data      = sample_data;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         wr_address <= '0;
      else if (wr_en)
         wr_address <= next_address;
   end

endmodule

`default_nettype wire

/* source/sample_buffer.sv */
`default_nettype none

module sample_buffer
(
   input  logic                          clk,
   input  logic                          wr_en,
   input  logic [acq_pkg::BUF_ADDR_W-1:0] wr_address,
   input  logic [acq_pkg::SAMPLE_W-1:0]   wr_data,
   input  logic [acq_pkg::BUF_ADDR_W-1:0] rd_address,
   output logic [acq_pkg::SAMPLE_W-1:0]   rd_data
);

   import acq_pkg::*;

   // simple dual-port block RAM
   logic [SAMPLE_W-1:0] mem [BUF_DEPTH];

   // write port
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_address] <= wr_data;
   end

   // registered read port, one cycle from address to data
   // a read of the word being written returns the old contents
   always_ff @(posedge clk)
   begin
      rd_data <= mem[rd_address];
   end

endmodule

`default_nettype wire

/* scheduler/transfer_scheduler.sv */
`default_nettype none

module transfer_scheduler
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [acq_pkg::BUF_ADDR_W-1:0]   wr_address,
   output logic [acq_pkg::BUF_ADDR_W-1:0]   rd_address,
   input  logic [acq_pkg::SAMPLE_W-1:0]     rd_data,
   input  logic                            read_done,
   input  logic                            cmd_ready,
   output logic                            cmd_enable,
   output acq_pkg::store_op_t              cmd_op,
   output logic [acq_pkg::STORE_ADDR_W-1:0] cmd_address,
   output logic [acq_pkg::STORE_DATA_W-1:0] cmd_data,
   output acq_pkg::sched_phase_t           phase
);

   import acq_pkg::*;

   // store pointers carry one extra bit, the top bit flags full / all read
   logic [STORE_ADDR_W:0] wr_ptr;
   logic [STORE_ADDR_W:0] rd_ptr;
   logic                  issue_wr;
   logic                  issue_rd;

   // a command goes out only after ready was seen high
   assign issue_wr = (phase == AQ_BUFFER_TO_STORE) && !cmd_enable && cmd_ready;
   assign issue_rd = (phase == RB_ISSUE) && cmd_ready;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         phase      <= AQ_WAITING;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         rd_address <= '0;
         cmd_enable <= 1'b0;
      end
      else
      begin
         cmd_enable <= 1'b0;  // enable is a single-cycle strobe
         case (phase)
            AQ_WAITING:
            begin
               if (wr_ptr[STORE_ADDR_W])
                  phase <= RB_ISSUE;  // store full, stop taking samples
               else if (rd_address != wr_address)
                  phase <= AQ_BUFFER_TO_STORE;
            end
            AQ_BUFFER_TO_STORE:
            begin
               // rd_data is valid here since rd_address settled earlier
               if (cmd_enable)
                  phase <= AQ_WAITING;  // write went out last cycle
               else if (issue_wr)
               begin
                  cmd_enable <= 1'b1;
                  wr_ptr     <= wr_ptr + 1'b1;
                  rd_address <= rd_address + 1'b1;
               end
            end
            RB_ISSUE:
            begin
               if (issue_rd)
               begin
                  cmd_enable <= 1'b1;
                  rd_ptr     <= rd_ptr + 1'b1;
                  phase      <= RB_IDLE;
               end
            end
            RB_IDLE:
            begin
               if (rd_ptr[STORE_ADDR_W])
                  phase <= FINISHED;
               else if (read_done)
                  phase <= RB_ISSUE;  // host has taken the last word
            end
            default:
               phase <= FINISHED;  // stays here until reset
         endcase
      end
   end

   // command payload, loaded alongside the enable strobe
   always_ff @(posedge clk)
   begin
      if (issue_wr)
      begin
         cmd_op      <= STORE_WRITE;
         cmd_address <= wr_ptr[STORE_ADDR_W-1:0];
         cmd_data    <= {{(STORE_DATA_W - SAMPLE_W){1'b0}}, rd_data};
      end
      else if (issue_rd)
      begin
         cmd_op      <= STORE_READ;
         cmd_address <= rd_ptr[STORE_ADDR_W-1:0];
      end
   end

endmodule

`default_nettype wire

/* scheduler/word_store.sv */
`default_nettype none

module word_store
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            cmd_enable,
   input  acq_pkg::store_op_t              cmd_op,
   input  logic [acq_pkg::STORE_ADDR_W-1:0] cmd_address,
   input  logic [acq_pkg::STORE_DATA_W-1:0] cmd_data,
   output logic                            cmd_ready,
   output logic [acq_pkg::STORE_DATA_W-1:0] store_data,
   output logic                            store_valid
);

   import acq_pkg::*;

   logic [STORE_DATA_W-1:0]   mem [STORE_DEPTH];
   logic [BUSY_CNT_W-1:0]     busy_cnt;
   logic [STORE_READ_LAT-1:0] valid_pipe;
   logic [STORE_DATA_W-1:0]   data_pipe [STORE_READ_LAT];

   // every accepted command makes the store busy for a few cycles
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         busy_cnt <= '0;
      else if (cmd_enable)
         busy_cnt <= BUSY_CNT_W'(STORE_BUSY);
      else if (busy_cnt != '0)
         busy_cnt <= busy_cnt - 1'b1;
   end

   assign cmd_ready = (busy_cnt == '0);

   // read strobe delay line
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         valid_pipe <= '0;
      else
         valid_pipe <= {valid_pipe[STORE_READ_LAT-2:0],
                        cmd_enable && (cmd_op == STORE_READ)};
   end

   always_ff @(posedge clk)
   begin
      if (cmd_enable && (cmd_op == STORE_WRITE))
         mem[cmd_address] <= cmd_data;
      data_pipe[0] <= mem[cmd_address];  // sampled every cycle, used on reads
      for (int i = 1; i < STORE_READ_LAT; i++)
         data_pipe[i] <= data_pipe[i-1];
   end

   // data and strobe leave the delay lines together
   assign store_data  = data_pipe[STORE_READ_LAT-1];
   assign store_valid = valid_pipe[STORE_READ_LAT-1];

endmodule

`default_nettype wire

/* source/acquire_top.sv */
`default_nettype none

module acquire_top
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            acquire,
   input  logic [acq_pkg::SAMPLE_W-1:0]     sample_data,
   input  logic                            read_done,
   output logic [acq_pkg::STORE_DATA_W-1:0] replay_data,
   output logic                            replay_valid,
   output acq_pkg::sched_phase_t           phase,
   output logic                            finished
);

   import acq_pkg::*;

   // writer to buffer
   logic                    wr_en;
   logic [BUF_ADDR_W-1:0]   wr_address;
   logic [SAMPLE_W-1:0]     wr_data;

   // buffer to scheduler
   logic [BUF_ADDR_W-1:0]   rd_address;
   logic [SAMPLE_W-1:0]     rd_data;

   // command port
   logic                    cmd_ready;
   logic                    cmd_enable;
   store_op_t               cmd_op;
   logic [STORE_ADDR_W-1:0] cmd_address;
   logic [STORE_DATA_W-1:0] cmd_data;

   capture_writer u_writer
   (
      .clk         (clk),
      .rst         (rst),
      .acquire     (acquire),
      .sample_data (sample_data),
      .rd_address  (rd_address),
      .wr_en       (wr_en),
      .wr_address  (wr_address),
      .wr_data     (wr_data)
   );

   sample_buffer u_buffer
   (
      .clk        (clk),
      .wr_en      (wr_en),
      .wr_address (wr_address),
      .wr_data    (wr_data),
      .rd_address (rd_address),
      .rd_data    (rd_data)
   );

   transfer_scheduler u_scheduler
   (
      .clk         (clk),
      .rst         (rst),
      .wr_address  (wr_address),
      .rd_address  (rd_address),
      .rd_data     (rd_data),
      .read_done   (read_done),
      .cmd_ready   (cmd_ready),
      .cmd_enable  (cmd_enable),
      .cmd_op      (cmd_op),
      .cmd_address (cmd_address),
      .cmd_data    (cmd_data),
      .phase       (phase)
   );

   word_store u_store
   (
      .clk         (clk),
      .rst         (rst),
      .cmd_enable  (cmd_enable),
      .cmd_op      (cmd_op),
      .cmd_address (cmd_address),
      .cmd_data    (cmd_data),
      .cmd_ready   (cmd_ready),
      .store_data  (replay_data),
      .store_valid (replay_valid)
   );

   assign finished = (phase == FINISHED);

endmodule

`default_nettype wire

/* tb/acquire_tb.sv */
`default_nettype none

module acquire_tb;

   import acq_pkg::*;

   logic                    clk;
   logic                    rst;
   logic                    acquire;
   logic [SAMPLE_W-1:0]     sample_data;
   logic                    read_done;
   logic [STORE_DATA_W-1:0] replay_data;
   logic                    replay_valid;
   sched_phase_t            phase;
   logic                    finished;

   logic [31:0]         rng_state;
   logic [SAMPLE_W-1:0] expected_q [$];  // samples in capture order

   acquire_top UUT
   (
      .clk          (clk),
      .rst          (rst),
      .acquire      (acquire),
      .sample_data  (sample_data),
      .read_done    (read_done),
      .replay_data  (replay_data),
      .replay_valid (replay_valid),
      .phase        (phase),
      .finished     (finished)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      string line;
      if (expected !== actual)
      begin
         line = $sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual);
         abort_run(line);
      end
   endtask

   // one-cycle acquire pulse, sample held well past the synchronizer delay
   task automatic drive_sample();
      logic [SAMPLE_W-1:0] value;
      rng_state = next_random(rng_state);
      value = rng_state[SAMPLE_W-1:0];
      expected_q.push_back(value);
      @(negedge clk);
      acquire     = 1'b1;
      sample_data = value;
      @(negedge clk);
      acquire = 1'b0;
      repeat (3) @(negedge clk);
      repeat (2) @(negedge clk);  // gap between samples
   endtask

   // no second strobe may follow the last request before the next one
   task automatic pulse_read_done();
      repeat (STORE_BUSY + STORE_READ_LAT)
      begin
         @(negedge clk);
         check("single valid per request", 32'd0, 32'(replay_valid));
      end
      read_done = 1'b1;
      @(negedge clk);
      read_done = 1'b0;
   endtask

   task automatic wait_replay(input int limit, input string what,
                              output logic [STORE_DATA_W-1:0] data);
      int n;
      n = 0;
      @(negedge clk);
      while (!replay_valid && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (!replay_valid)
         abort_run($sformatf("timed out waiting for replay_valid of %s", what));
      else
         data = replay_data;
   endtask

   task automatic reset_idle_test();
      repeat (20)
      begin
         @(negedge clk);
         check("reset idle phase", 32'(AQ_WAITING), 32'(phase));
         check("reset idle finished", 32'd0, 32'(finished));
         check("reset idle replay_valid", 32'd0, 32'(replay_valid));
      end
   endtask

   task automatic partial_capture_test();
      logic in_readback;
      repeat (10) drive_sample();
      repeat (10)
      begin
         @(negedge clk);
         in_readback = (phase == RB_ISSUE) || (phase == RB_IDLE) || (phase == FINISHED);
         check("partial capture phase", 32'd0, 32'(in_readback));
      end
   endtask

   task automatic first_replay_test();
      logic [STORE_DATA_W-1:0] data;
      repeat (6) drive_sample();
      wait_replay(200, "word 1", data);  // no read_done needed for this one
      check("first replay", {8'h00, expected_q.pop_front()}, data);
   endtask

   task automatic ordered_replay_test();
      logic [STORE_DATA_W-1:0] data;
      for (int i = 2; i <= STORE_DEPTH; i++)
      begin
         pulse_read_done();
         wait_replay(40, $sformatf("word %0d", i), data);
         check($sformatf("ordered replay word %0d", i), {8'h00, expected_q.pop_front()}, data);
      end
   endtask

   task automatic finish_test();
      int n;
      pulse_read_done();
      n = 0;
      while (!finished && n < 40)
      begin
         @(negedge clk);
         n++;
      end
      if (!finished)
         abort_run("timed out waiting for finished after the last word");
      check("finish phase", 32'(FINISHED), 32'(phase));
      // requests and samples must not wake the store again
      for (int i = 0; i < 50; i++)
      begin
         @(negedge clk);
         check("finish quiet replay_valid", 32'd0, 32'(replay_valid));
         check("finish held", 32'd1, 32'(finished));
         read_done = ((i % 10) == 3);
         acquire   = ((i % 10) == 6);
         if ((i % 10) == 6)
         begin
            rng_state   = next_random(rng_state);
            sample_data = rng_state[SAMPLE_W-1:0];
         end
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      acquire     = 1'b0;
      sample_data = '0;
      read_done   = 1'b0;
      rng_state   = 32'd84945;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      reset_idle_test();
      partial_capture_test();
      first_replay_test();
      ordered_replay_test();
      finish_test();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* acquire.f */
common/acq_pkg.sv
source/capture_writer.sv
source/sample_buffer.sv
scheduler/transfer_scheduler.sv
scheduler/word_store.sv
source/acquire_top.sv
tb/acquire_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the acquire testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module acquire_tb -f acquire.f -o acquire_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/acquire_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

echo "simulation finished without failure"
exit 0
